// ==== source/usb_bulk_pkg.sv ====
`default_nettype none

package usb_bulk_pkg;

  // PID bytes with their check nibble in the upper half
  typedef enum logic [7:0] {
    PID_OUT   = 8'hE1,
    PID_DATA0 = 8'hC3,
    PID_DATA1 = 8'h4B,
    PID_ACK   = 8'hD2,
    PID_NAK   = 8'h5A,
    PID_STALL = 8'h1E
  } usb_pid_t;

  // Endpoint FSM states
  typedef enum logic [2:0] {
    EP_HALT,  // Not configured, answers with STALL
    EP_IDLE,  // Waiting for an OUT token
    EP_RECV,  // Storing the data packet
    EP_DROP,  // Ignoring data, NAK or STALL pending
    EP_RESP   // Handshake goes out next
  } ep_state_t;

  // Endpoint this block answers to
  localparam logic [3:0] ENDPOINT_NUM = 4'd1;

  // Bytes per full packet, 512 for high speed
  localparam int MAX_PACKET = 8;

  // Byte counter, must hold MAX_PACKET itself
  localparam int CNT_W = $clog2(MAX_PACKET + 1);

  // Entries in the packet FIFO, a power of two
  localparam int FIFO_DEPTH = 32;

  // FIFO index width, pointers carry one extra wrap bit
  localparam int PTR_W = $clog2(FIFO_DEPTH);

  // Level count from empty up to FIFO_DEPTH
  localparam int LEVEL_W = $clog2(FIFO_DEPTH + 1);

endpackage

`default_nettype wire

// ==== source/usb_token_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module usb_token_decode
  import usb_bulk_pkg::*;
(
  input  wire        clock,
  input  wire        reset_i,
  input  wire        rx_tvalid_i,
  input  wire        rx_tlast_i,
  input  wire  [7:0] rx_tdata_i,
  input  wire        rx_crc_err_i,
  input  wire  [6:0] usb_addr_i,
  output logic       tok_out_o,
  output logic       dat_start_o,
  output usb_pid_t   dat_pid_o,
  output logic       dat_valid_o,
  output logic [7:0] dat_data_o,
  output logic       dat_last_o,
  output logic       dat_end_o,
  output logic       dat_crc_ok_o
);

  typedef enum logic [2:0] {DEC_PID, DEC_TOK1, DEC_TOK2, DEC_DATA, DEC_SKIP} dec_state_t;

  dec_state_t state_q;
  logic       matched_q;   // Last token was our OUT
  logic [7:0] tok_b1_q;    // Address and low endpoint bit
  logic       tok_match;
  usb_pid_t   rx_pid;

  assign rx_pid = usb_pid_t'(rx_tdata_i);

  // Endpoint number straddles the two token bytes
  assign tok_match = (tok_b1_q[6:0] == usb_addr_i) &&
                     ({rx_tdata_i[2:0], tok_b1_q[7]} == ENDPOINT_NUM);

  always_ff @(posedge clock) begin
    if (reset_i) begin
      state_q     <= DEC_PID;
      matched_q   <= 1'b0;
      tok_out_o   <= 1'b0;
      dat_start_o <= 1'b0;
      dat_valid_o <= 1'b0;
      dat_last_o  <= 1'b0;
      dat_end_o   <= 1'b0;
    end else begin
      tok_out_o   <= 1'b0;
      dat_start_o <= 1'b0;
      dat_valid_o <= 1'b0;
      dat_last_o  <= 1'b0;
      dat_end_o   <= 1'b0;
      if (rx_tvalid_i) begin
        case (state_q)
          DEC_PID: begin
            if (rx_tdata_i[1:0] == 2'b01) matched_q <= 1'b0; // Every token type
            if (rx_pid == PID_OUT) begin
              state_q <= rx_tlast_i ? DEC_PID : DEC_TOK1;
            end else if ((rx_pid == PID_DATA0 || rx_pid == PID_DATA1) && matched_q) begin
              dat_start_o  <= 1'b1;
              dat_pid_o    <= rx_pid;
              dat_end_o    <= rx_tlast_i;     // ZDP ends on its PID
              dat_crc_ok_o <= !rx_crc_err_i;
              state_q      <= rx_tlast_i ? DEC_PID : DEC_DATA;
            end else begin
              state_q <= rx_tlast_i ? DEC_PID : DEC_SKIP;
            end
          end
          DEC_TOK1: begin
            tok_b1_q <= rx_tdata_i;
            state_q  <= rx_tlast_i ? DEC_PID : DEC_TOK2;
          end
          DEC_TOK2: begin
            if (rx_tlast_i) begin
              tok_out_o <= tok_match;
              matched_q <= tok_match;
              state_q   <= DEC_PID;
            end else begin
              state_q <= DEC_SKIP;       // Too long for a token
            end
          end
          DEC_DATA: begin
            dat_valid_o <= 1'b1;
            dat_data_o  <= rx_tdata_i;
            dat_last_o  <= rx_tlast_i;
            if (rx_tlast_i) begin
              dat_end_o    <= 1'b1;
              dat_crc_ok_o <= !rx_crc_err_i;
              state_q      <= DEC_PID;
            end
          end
          default: begin
            if (rx_tlast_i) state_q <= DEC_PID;
          end
        endcase
      end
    end
  end

  // Data only flows behind an OUT token whose address and endpoint were ours
  a_data_after_token: assert property (@(posedge clock) disable iff (reset_i)
    (dat_start_o || dat_valid_o) |->
      ((tok_b1_q[6:0] == usb_addr_i) && (tok_b1_q[7] == ENDPOINT_NUM[0])));

endmodule

`default_nettype wire

// ==== source/ep_bulk_out.sv ====
`timescale 1ns/1ps
`default_nettype none

module ep_bulk_out
  import usb_bulk_pkg::*;
(
  input  wire               clock,
  input  wire               reset_i,
  input  wire               set_conf_i,
  input  wire               clr_conf_i,
  input  wire               tok_out_i,
  input  wire               dat_start_i,
  input  var usb_pid_t      dat_pid_i,
  input  wire               dat_valid_i,
  input  wire         [7:0] dat_data_i,
  input  wire               dat_last_i,
  input  wire               dat_end_i,
  input  wire               dat_crc_ok_i,
  input  wire [LEVEL_W-1:0] level_i,
  output logic              wr_valid_o,
  output logic        [7:0] wr_data_o,
  output logic              wr_last_o,
  output logic              wr_keep_o,
  output logic              save_o,
  output logic              drop_o,
  output logic              hs_valid_o,
  output usb_pid_t          hs_pid_o
);

  ep_state_t        state_q;
  logic             configured_q;
  logic             toggle_q;      // Low expects DATA0
  logic [CNT_W-1:0] cnt_q;         // Payload bytes so far
  usb_pid_t         resp_pid_q;
  logic             hs_valid_q;
  usb_pid_t         hs_pid_q;

  logic [CNT_W-1:0] cnt_w;
  logic             in_recv;
  logic             conf_w;
  logic             space_ok;
  logic             byte_fits;
  logic             good_pkt;
  logic             save_w;
  logic             zdp_w;
  usb_pid_t         expect_pid;

  assign cnt_w      = dat_start_i ? '0 : cnt_q;
  assign in_recv    = (state_q == EP_RECV);
  assign conf_w     = set_conf_i || clr_conf_i;
  assign space_ok   = level_i <= LEVEL_W'(FIFO_DEPTH - MAX_PACKET);
  assign byte_fits  = cnt_w < CNT_W'(MAX_PACKET);
  assign expect_pid = toggle_q ? PID_DATA1 : PID_DATA0;

  // Count saturates, so a babbling packet ends on a byte that does not fit
  assign good_pkt = dat_crc_ok_i && !(dat_valid_i && !byte_fits);
  assign save_w   = in_recv && dat_end_i && good_pkt && (dat_pid_i == expect_pid);
  assign zdp_w    = save_w && !dat_valid_i && (cnt_w == '0);

  always_comb begin
    wr_valid_o = in_recv && ((dat_valid_i && byte_fits) || zdp_w);
    wr_data_o  = zdp_w ? 8'h00 : dat_data_i;
    wr_keep_o  = !zdp_w;
    // Short packet closes the frame
    wr_last_o  = zdp_w || (dat_last_i && (cnt_w + 1'b1 < CNT_W'(MAX_PACKET)));
  end

  assign save_o = save_w;
  assign drop_o = in_recv && ((dat_end_i && !save_w) || conf_w || tok_out_i);

  always_ff @(posedge clock) begin
    if (reset_i) begin
      state_q      <= EP_HALT;
      configured_q <= 1'b0;
      toggle_q     <= 1'b0;
      cnt_q        <= '0;
      hs_valid_q   <= 1'b0;
    end else begin
      hs_valid_q <= (state_q == EP_RESP);
      if (clr_conf_i) begin
        configured_q <= 1'b0;
        state_q      <= EP_HALT;
      end else if (set_conf_i) begin
        configured_q <= 1'b1;
        toggle_q     <= 1'b0;
        state_q      <= EP_IDLE;
      end else if (tok_out_i && state_q != EP_RESP) begin
        cnt_q <= '0;
        if (!configured_q) begin
          resp_pid_q <= PID_STALL;
          state_q    <= EP_DROP;
        end else if (space_ok) begin
          state_q <= EP_RECV;
        end else begin
          resp_pid_q <= PID_NAK;  // No room for a full packet
          state_q    <= EP_DROP;
        end
      end else begin
        case (state_q)
          EP_RECV: begin
            cnt_q <= cnt_w + CNT_W'(dat_valid_i && byte_fits);
            if (dat_end_i) begin
              if (good_pkt) begin
                resp_pid_q <= PID_ACK;   // Repeats get ACK as well
                state_q    <= EP_RESP;
              end else begin
                state_q <= EP_IDLE;
              end
              if (save_w) toggle_q <= !toggle_q;
            end
          end
          EP_DROP: begin
            if (dat_end_i) begin
              if (dat_crc_ok_i) state_q <= EP_RESP;
              else state_q <= configured_q ? EP_IDLE : EP_HALT;
            end
          end
          EP_RESP: state_q <= configured_q ? EP_IDLE : EP_HALT;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clock) begin
    if (state_q == EP_RESP) hs_pid_q <= resp_pid_q;
  end

  assign hs_valid_o = hs_valid_q;
  assign hs_pid_o   = hs_pid_q;

  // Space check at token time keeps the FIFO from overflowing
  a_no_overflow: assert property (@(posedge clock) disable iff (reset_i)
    !(wr_valid_o && level_i == LEVEL_W'(FIFO_DEPTH)));

endmodule

`default_nettype wire

// ==== source/packet_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module packet_fifo
  import usb_bulk_pkg::*;
(
  input  wire               clock,
  input  wire               reset_i,
  input  wire               wr_valid_i,
  input  wire         [7:0] wr_data_i,
  input  wire               wr_last_i,
  input  wire               wr_keep_i,
  input  wire               save_i,
  input  wire               drop_i,
  output logic [LEVEL_W-1:0] level_o,
  output logic              m_tvalid_o,
  input  wire               m_tready_i,
  output logic        [7:0] m_tdata_o,
  output logic              m_tkeep_o,
  output logic              m_tlast_o
);

  // Entry layout is {last, keep, data}
  logic [9:0] mem [FIFO_DEPTH];

  logic [PTR_W:0] rd_ptr_q;   // Next entry for the sink
  logic [PTR_W:0] cm_ptr_q;   // End of committed packets
  logic [PTR_W:0] wr_ptr_q;   // End of pending packet
  logic [PTR_W:0] wr_ptr_nx;
  logic           avail;
  logic           load;
  logic     [9:0] out_q;
  logic           out_valid_q;

  assign wr_ptr_nx = wr_ptr_q + (PTR_W + 1)'(wr_valid_i);
  assign avail     = (cm_ptr_q != rd_ptr_q);
  assign load      = avail && (!out_valid_q || m_tready_i);

  // Pending plus committed, the output register is not counted
  assign level_o = LEVEL_W'(wr_ptr_q - rd_ptr_q);

  always_ff @(posedge clock) begin
    if (wr_valid_i && !drop_i) begin
      mem[wr_ptr_q[PTR_W-1:0]] <= {wr_last_i, wr_keep_i, wr_data_i};
    end
  end

  always_ff @(posedge clock) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      cm_ptr_q <= '0;
    end else if (drop_i) begin
      wr_ptr_q <= cm_ptr_q;             // Rewind the pending packet
    end else begin
      wr_ptr_q <= wr_ptr_nx;
      if (save_i) cm_ptr_q <= wr_ptr_nx; // Includes a same-cycle write
    end
  end

  // Output register, refilled as soon as it empties
  always_ff @(posedge clock) begin
    if (reset_i) begin
      rd_ptr_q    <= '0;
      out_valid_q <= 1'b0;
    end else if (load) begin
      rd_ptr_q    <= rd_ptr_q + 1'b1;
      out_valid_q <= 1'b1;
    end else if (m_tready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (load) out_q <= mem[rd_ptr_q[PTR_W-1:0]];
  end

  assign m_tvalid_o = out_valid_q;
  assign m_tdata_o  = out_q[7:0];
  assign m_tkeep_o  = out_q[8];
  assign m_tlast_o  = out_q[9];

  // Sink stream holds still under back-pressure
  a_sink_stable: assert property (@(posedge clock) disable iff (reset_i)
    (m_tvalid_o && !m_tready_i) |=>
      (m_tvalid_o && $stable({m_tdata_o, m_tkeep_o, m_tlast_o})));

endmodule

`default_nettype wire

// ==== source/usb_bulk_out_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module usb_bulk_out_top
  import usb_bulk_pkg::*;
(
  input  wire        clock,
  input  wire        reset_i,
  input  wire        rx_tvalid_i,
  input  wire        rx_tlast_i,
  input  wire  [7:0] rx_tdata_i,
  input  wire        rx_crc_err_i,
  input  wire        set_conf_i,
  input  wire        clr_conf_i,
  input  wire  [6:0] usb_addr_i,
  output logic       m_tvalid_o,
  input  wire        m_tready_i,
  output logic [7:0] m_tdata_o,
  output logic       m_tkeep_o,
  output logic       m_tlast_o,
  output logic       hs_valid_o,
  output usb_pid_t   hs_pid_o
);

  // Decode to endpoint
  wire               tok_out;
  wire               dat_start;
  usb_pid_t          dat_pid;
  wire               dat_valid;
  wire         [7:0] dat_data;
  wire               dat_last;
  wire               dat_end;
  wire               dat_crc_ok;

  // Endpoint to FIFO
  wire               wr_valid;
  wire         [7:0] wr_data;
  wire               wr_last;
  wire               wr_keep;
  wire               save;
  wire               drop;
  wire [LEVEL_W-1:0] level;

  usb_token_decode u_decode (
    .clock        (clock),
    .reset_i      (reset_i),
    .rx_tvalid_i  (rx_tvalid_i),
    .rx_tlast_i   (rx_tlast_i),
    .rx_tdata_i   (rx_tdata_i),
    .rx_crc_err_i (rx_crc_err_i),
    .usb_addr_i   (usb_addr_i),
    .tok_out_o    (tok_out),
    .dat_start_o  (dat_start),
    .dat_pid_o    (dat_pid),
    .dat_valid_o  (dat_valid),
    .dat_data_o   (dat_data),
    .dat_last_o   (dat_last),
    .dat_end_o    (dat_end),
    .dat_crc_ok_o (dat_crc_ok)
  );

  ep_bulk_out u_endpoint (
    .clock        (clock),
    .reset_i      (reset_i),
    .set_conf_i   (set_conf_i),
    .clr_conf_i   (clr_conf_i),
    .tok_out_i    (tok_out),
    .dat_start_i  (dat_start),
    .dat_pid_i    (dat_pid),
    .dat_valid_i  (dat_valid),
    .dat_data_i   (dat_data),
    .dat_last_i   (dat_last),
    .dat_end_i    (dat_end),
    .dat_crc_ok_i (dat_crc_ok),
    .level_i      (level),
    .wr_valid_o   (wr_valid),
    .wr_data_o    (wr_data),
    .wr_last_o    (wr_last),
    .wr_keep_o    (wr_keep),
    .save_o       (save),
    .drop_o       (drop),
    .hs_valid_o   (hs_valid_o),
    .hs_pid_o     (hs_pid_o)
  );

  packet_fifo u_fifo (
    .clock      (clock),
    .reset_i    (reset_i),
    .wr_valid_i (wr_valid),
    .wr_data_i  (wr_data),
    .wr_last_i  (wr_last),
    .wr_keep_i  (wr_keep),
    .save_i     (save),
    .drop_i     (drop),
    .level_o    (level),
    .m_tvalid_o (m_tvalid_o),
    .m_tready_i (m_tready_i),
    .m_tdata_o  (m_tdata_o),
    .m_tkeep_o  (m_tkeep_o),
    .m_tlast_o  (m_tlast_o)
  );

endmodule

`default_nettype wire

// ==== testbench/usb_bulk_out_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module usb_bulk_out_tb
  import usb_bulk_pkg::*;
();

  localparam logic [6:0] DEV_ADDR   = 7'h2A;
  localparam logic [6:0] OTHER_ADDR = 7'h15;

  // One transaction, with config action 0 none, 1 set, 2 clear
  typedef struct packed {
    logic [1:0] cfg;
    logic [6:0] addr;
    usb_pid_t   pid;
    logic [7:0] len;
    logic       crc_err;
    logic       stall;
    logic       hs_exp;
    usb_pid_t   hs_pid;
    logic       stored;
  } row_t;

  logic       clock = 1'b0;
  logic       reset_i;
  logic       rx_tvalid_i;
  logic       rx_tlast_i;
  logic [7:0] rx_tdata_i;
  logic       rx_crc_err_i;
  logic       set_conf_i;
  logic       clr_conf_i;
  logic [6:0] usb_addr_i;
  logic       m_tready_i = 1'b0;
  logic       m_tvalid_o;
  logic [7:0] m_tdata_o;
  logic       m_tkeep_o;
  logic       m_tlast_o;
  logic       hs_valid_o;
  usb_pid_t   hs_pid_o;

  row_t       rows [$];
  logic [7:0] tx_q [$];      // Bytes of the packet being sent
  logic [9:0] exp_q [$];     // Expected sink entries {last, keep, data}
  bit         ready_pat [256];
  logic       sink_stall = 1'b0;
  int         cycle_count = 0;
  int         cycle_limit = 100000;

  usb_bulk_out_top DUT (
    .clock        (clock),
    .reset_i      (reset_i),
    .rx_tvalid_i  (rx_tvalid_i),
    .rx_tlast_i   (rx_tlast_i),
    .rx_tdata_i   (rx_tdata_i),
    .rx_crc_err_i (rx_crc_err_i),
    .set_conf_i   (set_conf_i),
    .clr_conf_i   (clr_conf_i),
    .usb_addr_i   (usb_addr_i),
    .m_tvalid_o   (m_tvalid_o),
    .m_tready_i   (m_tready_i),
    .m_tdata_o    (m_tdata_o),
    .m_tkeep_o    (m_tkeep_o),
    .m_tlast_o    (m_tlast_o),
    .hs_valid_o   (hs_valid_o),
    .hs_pid_o     (hs_pid_o)
  );

  always #50 clock = ~clock;

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Finished with errors");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Error at time %0t: %s is %02h, expected %02h",
                              $time, name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Error at time %0t: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_pid(input string name, input usb_pid_t got, input usb_pid_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Error at time %0t: %s is %s (%02h), expected %s (%02h)",
                              $time, name, got.name(), got, exp.name(), exp));
    end
  endtask

  task automatic add_row(input logic [1:0] cfg, input logic [6:0] addr, input usb_pid_t pid,
                         input logic [7:0] len, input logic crc_err, input logic stall,
                         input logic hs_exp, input usb_pid_t hs_pid, input logic stored);
    rows.push_back('{cfg, addr, pid, len, crc_err, stall, hs_exp, hs_pid, stored});
  endtask

  // Called on a falling edge, returns on the falling edge after the last byte
  task automatic send_bytes(input logic crc_err);
    int i;
    for (i = 0; i < tx_q.size(); i++) begin
      rx_tvalid_i  = 1'b1;
      rx_tdata_i   = tx_q[i];
      rx_tlast_i   = (i == tx_q.size() - 1);
      rx_crc_err_i = crc_err && rx_tlast_i;  // Flag rides on the last byte only
      @(negedge clock);
    end
    rx_tvalid_i  = 1'b0;
    rx_tlast_i   = 1'b0;
    rx_crc_err_i = 1'b0;
  endtask

  task automatic send_token(input logic [6:0] addr);
    tx_q.delete();
    tx_q.push_back(PID_OUT);
    tx_q.push_back({ENDPOINT_NUM[0], addr});
    tx_q.push_back({5'b00000, ENDPOINT_NUM[3:1]});  // CRC5 bits left at zero
    send_bytes(1'b0);
  endtask

  // Handshake must show on the third falling edge after the last byte, nowhere else
  task automatic check_handshake(input row_t r);
    int   k;
    logic exp_hs;
    for (k = 1; k <= 6; k++) begin
      if (k > 1) @(negedge clock);
      exp_hs = r.hs_exp && (k == 3);
      check_flag("hs_valid_o", hs_valid_o, exp_hs);
      if (exp_hs) check_pid("hs_pid_o", hs_pid_o, r.hs_pid);
    end
  endtask

  task automatic drain_sink();
    sink_stall <= 1'b0;
    @(posedge clock);
    while (exp_q.size() != 0) @(posedge clock);
    @(negedge clock);
  endtask

  // Sink model decides ready and checks each entry that will transfer on the next edge
  always @(negedge clock) begin : sink_model
    logic [9:0] exp_e;
    if (reset_i) begin
      m_tready_i = 1'b0;
    end else begin
      m_tready_i = !sink_stall && ready_pat[cycle_count[7:0]];
      if (m_tvalid_o && m_tready_i) begin
        if (exp_q.size() == 0) begin
          stop_on_error("The sink received an entry that no stored packet accounts for");
        end else begin
          exp_e = exp_q.pop_front();
          check_flag("m_tkeep_o", m_tkeep_o, exp_e[8]);
          check_flag("m_tlast_o", m_tlast_o, exp_e[9]);
          if (exp_e[8]) check_byte("m_tdata_o", m_tdata_o, exp_e[7:0]);
        end
      end
    end
  end

  always @(posedge clock) begin : watchdog
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      stop_on_error($sformatf("Timeout: the run did not end within %0d cycles", cycle_limit));
    end
  end

  initial begin : stimulus
    row_t        r;
    int          i;
    int          j;
    int          len_i;
    logic [31:0] rnd;
    logic  [7:0] b;
    ep_state_t   st;
    reset_i      = 1'b1;
    rx_tvalid_i  = 1'b0;
    rx_tlast_i   = 1'b0;
    rx_tdata_i   = 8'h00;
    rx_crc_err_i = 1'b0;
    set_conf_i   = 1'b0;
    clr_conf_i   = 1'b0;
    usb_addr_i   = DEV_ADDR;
    void'($urandom(19168));
    for (i = 0; i < 256; i++) begin
      rnd = $urandom();
      ready_pat[i] = rnd[0];
    end

    //      cfg   addr        pid        len crc stall hs  hs_pid     stored
    add_row(2'd0, DEV_ADDR,   PID_DATA0, 4,  0,  0,    1,  PID_STALL, 0);  // Not configured
    add_row(2'd0, OTHER_ADDR, PID_DATA0, 4,  0,  0,    0,  PID_ACK,   0);  // Foreign address
    add_row(2'd1, DEV_ADDR,   PID_DATA0, 5,  0,  0,    1,  PID_ACK,   1);
    add_row(2'd0, DEV_ADDR,   PID_DATA1, 8,  0,  0,    1,  PID_ACK,   1);
    add_row(2'd0, DEV_ADDR,   PID_DATA0, 8,  0,  0,    1,  PID_ACK,   1);
    add_row(2'd0, DEV_ADDR,   PID_DATA1, 0,  0,  0,    1,  PID_ACK,   1);  // ZDP ends the frame
    add_row(2'd0, DEV_ADDR,   PID_DATA1, 3,  0,  0,    1,  PID_ACK,   0);  // Repeat
    add_row(2'd0, DEV_ADDR,   PID_DATA0, 6,  1,  0,    0,  PID_ACK,   0);  // Bad CRC
    add_row(2'd0, DEV_ADDR,   PID_DATA0, 6,  0,  0,    1,  PID_ACK,   1);
    add_row(2'd0, DEV_ADDR,   PID_DATA1, 8,  0,  1,    1,  PID_ACK,   1);
    add_row(2'd0, DEV_ADDR,   PID_DATA0, 8,  0,  1,    1,  PID_ACK,   1);
    add_row(2'd0, DEV_ADDR,   PID_DATA1, 8,  0,  1,    1,  PID_ACK,   1);
    add_row(2'd0, DEV_ADDR,   PID_DATA0, 8,  0,  1,    1,  PID_ACK,   1);
    add_row(2'd0, DEV_ADDR,   PID_DATA1, 8,  0,  1,    1,  PID_NAK,   0);  // FIFO too full
    add_row(2'd0, DEV_ADDR,   PID_DATA1, 8,  0,  0,    1,  PID_ACK,   1);  // Retry
    add_row(2'd2, DEV_ADDR,   PID_DATA0, 2,  0,  0,    1,  PID_STALL, 0);

    cycle_limit = 24;  // Reset and final idle
    foreach (rows[i]) cycle_limit += int'(rows[i].len) + 40;

    repeat (4) @(negedge clock);
    reset_i = 1'b0;
    check_flag("hs_valid_o", hs_valid_o, 1'b0);
    check_flag("m_tvalid_o", m_tvalid_o, 1'b0);

    for (i = 0; i < rows.size(); i++) begin
      r     = rows[i];
      len_i = int'(r.len);
      if (!r.stall) drain_sink();
      sink_stall <= r.stall;
      st = DUT.u_endpoint.state_q;
      $display("Row %0d with %s, endpoint in %s", i, r.pid.name(), st.name());
      if (r.cfg == 2'd1) set_conf_i = 1'b1;
      else if (r.cfg == 2'd2) clr_conf_i = 1'b1;
      if (r.cfg != 2'd0) begin
        @(negedge clock);
        set_conf_i = 1'b0;
        clr_conf_i = 1'b0;
      end
      send_token(r.addr);
      tx_q.delete();
      tx_q.push_back(r.pid);
      for (j = 0; j < len_i; j++) begin
        rnd = $urandom();
        b   = rnd[7:0];
        tx_q.push_back(b);
        // Only a short packet closes the frame
        if (r.stored) exp_q.push_back({(j == len_i - 1) && (len_i < MAX_PACKET), 1'b1, b});
      end
      if (r.stored && len_i == 0) exp_q.push_back({1'b1, 1'b0, 8'h00});
      send_bytes(r.crc_err);
      check_handshake(r);
      if (!r.stall) drain_sink();
    end

    drain_sink();
    repeat (10) @(negedge clock);  // Nothing extra may reach the sink
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
source/usb_bulk_pkg.sv
source/usb_token_decode.sv
source/ep_bulk_out.sv
source/packet_fifo.sv
source/usb_bulk_out_top.sv
testbench/usb_bulk_out_tb.sv

// ==== Makefile ====
VERILATOR := verilator
TOP       := usb_bulk_out_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
FLAGS     := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) -f $(FILELIST)

# The binary exits non-zero on $fatal, so make fails with the test
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
